/* scuIntUnit.f */
+incdir+rtl
rtl/scuRegPkg.sv
rtl/scuIntPkg.sv
rtl/hostBusPort.sv
rtl/irqEdgeSync.sv
rtl/scuRegisters.sv
rtl/scuTimers.sv
rtl/intController.sv
rtl/scuIntUnit.sv
verification/scuIntUnit_assertions.sv
verification/scuIntUnitTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = scuIntUnitTb
FILELIST = scuIntUnit.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/scuIntUnitTb.sv */
`timescale 1ns/1ps
`include "scu_defs.svh"

module scuIntUnitTb
	import scuRegPkg::*;
	import scuIntPkg::*;
();
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	// Cycle budget of each test, summed for the watchdog
	localparam int LEN_FLAGS = 40;
	localparam int LEN_MASK = 40;
	localparam int LEN_FETCH = 120;
	localparam int LEN_CLEAR = 50;
	localparam int LEN_TIMER = 360;
	localparam int LEN_SOFT = 40;
	localparam int TOTAL_CYCLES = RESET_CYCLES + LEN_FLAGS + LEN_MASK + LEN_FETCH + LEN_CLEAR
		+ LEN_TIMER + LEN_SOFT;

	logic        CLK;
	logic        RST_N;
	logic        resN;
	logic [24:0] cpuAddr;
	logic [31:0] cpuWriteData;
	logic [31:0] cpuReadData;
	logic        regCsN;
	logic [3:0]  byteEnN;
	logic        readN;
	logic        vecFetchN;
	logic [3:0]  irqLevelN;
	logic        vblankN;
	logic        hblankN;
	logic        soundIrqN;
	logic        spriteIrqN;
	logic        smpcIrqN;

	// Pending checks handed to the compare process
	string       chkName[$];
	logic [31:0] chkExp[$];
	logic [31:0] chkAct[$];
	int          chkKind[$];
	int          checkCount = 0;
	int          errCount = 0;
	int          testErrBase = 0;

	logic [15:0] modelFlags;
	logic [15:0] modelMask;

	scuIntUnit i_dut (.CLK(CLK), .RST_N(RST_N), .resN(resN), .cpuAddr(cpuAddr),
		.cpuWriteData(cpuWriteData), .cpuReadData(cpuReadData), .regCsN(regCsN),
		.byteEnN(byteEnN), .readN(readN), .vecFetchN(vecFetchN), .irqLevelN(irqLevelN),
		.vblankN(vblankN), .hblankN(hblankN), .soundIrqN(soundIrqN),
		.spriteIrqN(spriteIrqN), .smpcIrqN(smpcIrqN));

	bind scuIntUnit scuIntUnitAssertions i_assertions (.CLK(CLK), .RST_N(RST_N),
		.irqLevelN(irqLevelN), .regWrite(regWrite), .regRead(regRead),
		.vecFetch(vecFetch), .flags(flags), .ims(ims));

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// Priority order of the unit, highest first
	function automatic irqLevelT refLevel(logic [15:0] f, logic [15:0] m);
		logic [15:0] act;
		act = f & ~m;
		if (act[0]) return 4'hF;
		if (act[1]) return 4'hE;
		if (act[2]) return 4'hD;
		if (act[3]) return 4'hC;
		if (act[4]) return 4'hB;
		if (act[6]) return 4'h9;
		if (act[7]) return 4'h8;
		if (act[13]) return 4'h2;
		return 4'h0;
	endfunction

	function automatic vectorT refVector(irqLevelT lvl);
		case (lvl)
			4'hF: return 8'h40;
			4'hE: return 8'h41;
			4'hD: return 8'h42;
			4'hC: return 8'h43;
			4'hB: return 8'h44;
			4'h9: return 8'h46;
			4'h8: return 8'h47;
			4'h2: return 8'h4D;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [15:0] levelFlag(irqLevelT lvl);
		case (lvl)
			4'hF: return 16'h0001;
			4'hE: return 16'h0002;
			4'hD: return 16'h0004;
			4'hC: return 16'h0008;
			4'hB: return 16'h0010;
			4'h9: return 16'h0040;
			4'h8: return 16'h0080;
			4'h2: return 16'h2000;
			default: return 16'h0000;
		endcase
	endfunction

	// Select bits: vblank, hblank, sound, sprite, smpc
	function automatic logic [15:0] requestFlags(logic [4:0] sel);
		logic [15:0] f;
		f = 16'h0000;
		if (sel[4]) f = f | 16'h0003;
		if (sel[3]) f = f | 16'h0004;
		if (sel[2]) f = f | 16'h0040;
		if (sel[1]) f = f | 16'h2000;
		if (sel[0]) f = f | 16'h0080;
		return f;
	endfunction

	task automatic checkWord(string name, logic [31:0] expVal, logic [31:0] actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			$display("Error %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkLevel(string name, irqLevelT expVal, irqLevelT actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			$display("Error %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkVector(string name, vectorT expVal, vectorT actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			$display("Error %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	// Kind 0 word, 1 level, 2 vector, 3 end of test
	task automatic postCheck(string name, int kind, logic [31:0] expVal, logic [31:0] actVal);
		chkName.push_back(name);
		chkExp.push_back(expVal);
		chkAct.push_back(actVal);
		chkKind.push_back(kind);
	endtask

	task automatic idleCycles(int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic writeReg(logic [7:0] ofs, logic [31:0] data);
		@(negedge CLK);
		cpuAddr = `SCU_REG_BASE + {17'h00000, ofs};
		cpuWriteData = data;
		regCsN = 1'b0;
		byteEnN = 4'b0000;
		// Lanes stay low until the register block has taken the write
		idleCycles(2);
		byteEnN = 4'b1111;
		regCsN = 1'b1;
		idleCycles(2);
	endtask

	task automatic readReg(logic [7:0] ofs, output logic [31:0] data);
		@(negedge CLK);
		cpuAddr = `SCU_REG_BASE + {17'h00000, ofs};
		regCsN = 1'b0;
		readN = 1'b0;
		@(negedge CLK);
		readN = 1'b1;
		regCsN = 1'b1;
		@(negedge CLK);
		data = cpuReadData;
	endtask

	task automatic fetchVector(irqLevelT lvl, output logic [31:0] data);
		@(negedge CLK);
		cpuAddr = {21'h000000, lvl};
		vecFetchN = 1'b0;
		readN = 1'b0;
		@(negedge CLK);
		readN = 1'b1;
		vecFetchN = 1'b1;
		@(negedge CLK);
		data = cpuReadData;
	endtask

	// vblank leads by one cycle so its rising edge lines up with the others
	task automatic pulseRequests(logic [4:0] sel);
		@(negedge CLK);
		if (sel[4]) begin
			vblankN = 1'b0;
			@(negedge CLK);
			vblankN = 1'b1;
		end
		hblankN = !sel[3];
		soundIrqN = !sel[2];
		spriteIrqN = !sel[1];
		smpcIrqN = !sel[0];
		@(negedge CLK);
		hblankN = 1'b1;
		soundIrqN = 1'b1;
		spriteIrqN = 1'b1;
		smpcIrqN = 1'b1;
		idleCycles(4);
		modelFlags = modelFlags | requestFlags(sel);
	endtask

	task automatic checkFlagsAndLevel(string name);
		logic [31:0] word;
		readReg(`OFS_IST, word);
		postCheck({name, " IST"}, 0, {16'h0000, modelFlags}, word);
		postCheck({name, " level"}, 1, {28'h0, ~refLevel(modelFlags, modelMask)},
			{28'h0, irqLevelN});
	endtask

	function automatic logic [4:0] randomSelect();
		logic [4:0] sel;
		sel = 5'($urandom());
		if (sel == 5'b00000) sel = 5'b00100;
		return sel;
	endfunction

	task automatic runTimerPhase(string name, int t0cVal);
		logic [31:0] word;
		pulseRequests(5'b10000);
		writeReg(`OFS_IST, 32'h0);
		modelFlags = 16'h0000;
		repeat (t0cVal) pulseRequests(5'b01000);
		readReg(`OFS_IST, word);
		postCheck({name, " before hit"}, 0, 32'h0, {31'h0, word[3]});
		pulseRequests(5'b01000);
		readReg(`OFS_IST, word);
		postCheck({name, " at hit"}, 0, 32'h1, {31'h0, word[3]});
	endtask

	// Compare process
	initial begin
		string       name;
		logic [31:0] e;
		logic [31:0] a;
		int          kind;
		forever begin
			@(posedge CLK);
			while (chkKind.size() > 0) begin
				name = chkName.pop_front();
				e = chkExp.pop_front();
				a = chkAct.pop_front();
				kind = chkKind.pop_front();
				case (kind)
					0: checkWord(name, e, a);
					1: checkLevel(name, irqLevelT'(e[3:0]), irqLevelT'(a[3:0]));
					2: checkVector(name, vectorT'(e[7:0]), vectorT'(a[7:0]));
					default: begin
						$display("Test %s finished, %0d errors", name,
							errCount - testErrBase);
						testErrBase = errCount;
					end
				endcase
			end
		end
	end

	initial begin
		#(2 * TOTAL_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] word;
		logic [15:0] keep;
		irqLevelT    lvl;
		int          t0cVal;
		void'($urandom(32'hd38e87c8));
		RST_N = 1'b0;
		resN = 1'b1;
		cpuAddr = '0;
		cpuWriteData = '0;
		regCsN = 1'b1;
		byteEnN = 4'b1111;
		readN = 1'b1;
		vecFetchN = 1'b1;
		vblankN = 1'b1;
		hblankN = 1'b1;
		soundIrqN = 1'b1;
		spriteIrqN = 1'b1;
		smpcIrqN = 1'b1;
		modelFlags = 16'h0000;
		modelMask = 16'h0000;
		idleCycles(RESET_CYCLES);
		RST_N = 1'b1;
		idleCycles(2);

		pulseRequests(randomSelect());
		checkFlagsAndLevel("flags");
		postCheck("flags", 3, 0, 0);

		writeReg(`OFS_IST, 32'h0);
		modelFlags = 16'h0000;
		modelMask = 16'($urandom());
		writeReg(`OFS_IMS, {16'h0000, modelMask});
		pulseRequests(randomSelect());
		checkFlagsAndLevel("mask");
		postCheck("mask", 3, 0, 0);

		for (int i = 0; i < 8; i++) begin
			lvl = refLevel(modelFlags, modelMask);
			if (lvl != 4'h0) begin
				fetchVector(lvl, word);
				postCheck("fetch vector", 2, {24'h0, refVector(lvl)}, word);
				postCheck("fetch upper bits", 0, 32'h0, word & 32'hFFFFFF00);
				modelFlags = modelFlags & ~levelFlag(lvl);
				idleCycles(3);
				checkFlagsAndLevel("fetch");
			end
		end
		postCheck("fetch", 3, 0, 0);

		pulseRequests(randomSelect());
		keep = 16'($urandom());
		writeReg(`OFS_IST, {16'h0000, keep});
		modelFlags = modelFlags & keep;
		idleCycles(2);
		checkFlagsAndLevel("clear");
		postCheck("clear", 3, 0, 0);

		writeReg(`OFS_IMS, 32'h0);
		modelMask = 16'h0000;
		t0cVal = int'($urandom_range(19, 0));
		writeReg(`OFS_T0C, t0cVal);
		writeReg(`OFS_T1MD, 32'h1);
		runTimerPhase("timer0", t0cVal);
		runTimerPhase("timer0 restart", t0cVal);
		writeReg(`OFS_T1MD, 32'h0);
		writeReg(`OFS_IST, 32'h0);
		modelFlags = 16'h0000;
		postCheck("timer0", 3, 0, 0);

		modelMask = 16'($urandom());
		writeReg(`OFS_IMS, {16'h0000, modelMask});
		writeReg(`OFS_T0C, 32'h3FF);
		writeReg(`OFS_T1S, 32'h1FF);
		// Mode bit only, so the timers stay idle
		writeReg(`OFS_T1MD, 32'h100);
		pulseRequests(5'b11111);
		@(negedge CLK);
		resN = 1'b0;
		idleCycles(2);
		resN = 1'b1;
		idleCycles(2);
		modelFlags = 16'h0000;
		modelMask = 16'h0000;
		checkFlagsAndLevel("soft reset");
		postCheck("soft reset ims", 0, 32'h0, {16'h0, i_dut.ims});
		postCheck("soft reset t0c", 0, 32'h0, {22'h0, i_dut.t0c});
		postCheck("soft reset t1s", 0, 32'h0, {23'h0, i_dut.t1s});
		postCheck("soft reset t1md", 0, 32'h0, {30'h0, i_dut.t1md});
		postCheck("soft reset", 3, 0, 0);

		while (chkKind.size() != 0) @(negedge CLK);
		$display("Checks run %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* verification/scuIntUnit_assertions.sv */
`timescale 1ns/1ps

module scuIntUnitAssertions (
	input logic        CLK,
	input logic        RST_N,
	input logic [3:0]  irqLevelN,
	input logic        regWrite,
	input logic        regRead,
	input logic        vecFetch,
	input logic [15:0] flags,
	input logic [15:0] ims
);
	// No request to the CPU while held in reset
	assert property (@(posedge CLK) !RST_N |-> (irqLevelN == 4'hF))
		else $error("irqLevelN is not idle during reset");

	// Bus access pulses last a single cycle
	assert property (@(posedge CLK) disable iff (!RST_N) regWrite |=> !regWrite)
		else $error("regWrite pulse longer than one cycle");
	assert property (@(posedge CLK) disable iff (!RST_N) regRead |=> !regRead)
		else $error("regRead pulse longer than one cycle");
	assert property (@(posedge CLK) disable iff (!RST_N) vecFetch |=> !vecFetch)
		else $error("vecFetch pulse longer than one cycle");

	// A level is only raised for an unmasked pending flag
	assert property (@(posedge CLK) disable iff (!RST_N)
		(irqLevelN != 4'hF) |-> ((flags & ~ims) != 16'h0000))
		else $error("interrupt level raised with no unmasked flag");

endmodule

/* rtl/scuIntUnit.sv */
`timescale 1ns/1ps

module scuIntUnit
	import scuRegPkg::*;
	import scuIntPkg::*;
(
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        resN,
	input  logic [24:0] cpuAddr,
	input  logic [31:0] cpuWriteData,
	output logic [31:0] cpuReadData,
	input  logic        regCsN,
	input  logic [3:0]  byteEnN,
	input  logic        readN,
	input  logic        vecFetchN,
	output logic [3:0]  irqLevelN,
	input  logic        vblankN,
	input  logic        hblankN,
	input  logic        soundIrqN,
	input  logic        spriteIrqN,
	input  logic        smpcIrqN
);
	logic       regWrite;
	logic       regRead;
	logic       vecFetch;
	regOfsT     regOfs;
	logic [31:0] regReadWord;
	vectorT     vector;
	edgeEventsT edgeEvents;
	t0cT        t0c;
	t1sT        t1s;
	t1mdT       t1md;
	imsT        ims;
	logic       tm0Hit;
	logic       tm1Hit;
	intFlagsU   flags;

	hostBusPort i_hostBusPort (.CLK, .RST_N, .resN, .cpuAddr, .cpuWriteData, .regCsN,
		.byteEnN, .readN, .vecFetchN, .regReadWord, .vector, .regWrite, .regRead,
		.vecFetch, .regOfs, .cpuReadData);

	irqEdgeSync i_irqEdgeSync (.CLK, .RST_N, .resN, .vblankN, .hblankN, .soundIrqN,
		.spriteIrqN, .smpcIrqN, .edgeEvents);

	scuRegisters i_scuRegisters (.CLK, .RST_N, .resN, .regWrite, .regRead, .regOfs,
		.byteEnN, .cpuWriteData, .flags, .t0c, .t1s, .t1md, .ims, .regReadWord);

	scuTimers i_scuTimers (.CLK, .RST_N, .resN, .edgeEvents, .t0c, .t1s, .t1md,
		.tm0Hit, .tm1Hit);

	intController i_intController (.CLK, .RST_N, .resN, .edgeEvents, .tm0Hit, .tm1Hit,
		.ims, .regWrite, .regOfs, .cpuWriteData, .vecFetch, .cpuAddr(cpuAddr[3:0]),
		.flags, .irqLevelN, .vector);

endmodule

/* rtl/intController.sv */
`timescale 1ns/1ps
`include "scu_defs.svh"

module intController
	import scuRegPkg::*;
	import scuIntPkg::*;
(
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        resN,
	input  edgeEventsT  edgeEvents,
	input  logic        tm0Hit,
	input  logic        tm1Hit,
	input  imsT         ims,
	input  logic        regWrite,
	input  regOfsT      regOfs,
	input  logic [31:0] cpuWriteData,
	input  logic        vecFetch,
	input  logic [3:0]  cpuAddr,
	output intFlagsU    flags,
	output logic [3:0]  irqLevelN,
	output vectorT      vector
);
	intFlagsU flagsNext;
	intFlagsU active;
	irqLevelT level;
	irqLevelT scanLevel;
	logic     istWrite;

	assign istWrite = regWrite && ({regOfs, 2'b00} == `OFS_IST);

	always_comb begin
		flagsNext = flags;
		// A zero data bit clears, reserved bits stay zero
		if (istWrite) flagsNext.raw = flags.raw & cpuWriteData[15:0];
		if (vecFetch) begin
			case (cpuAddr)
				4'hF: flagsNext.named.vbIn = 1'b0;
				4'hE: flagsNext.named.vbOut = 1'b0;
				4'hD: flagsNext.named.hbIn = 1'b0;
				4'hC: flagsNext.named.tm0 = 1'b0;
				4'hB: flagsNext.named.tm1 = 1'b0;
				4'h9: flagsNext.named.scsp = 1'b0;
				4'h8: flagsNext.named.sm = 1'b0;
				4'h2: flagsNext.named.vdp1 = 1'b0;
				default: ;
			endcase
		end
		// New events are never lost to a clear in the same cycle
		if (edgeEvents.vbIn) flagsNext.named.vbIn = 1'b1;
		if (edgeEvents.vbOut) flagsNext.named.vbOut = 1'b1;
		if (edgeEvents.hbIn) flagsNext.named.hbIn = 1'b1;
		if (tm0Hit) flagsNext.named.tm0 = 1'b1;
		if (tm1Hit) flagsNext.named.tm1 = 1'b1;
		if (edgeEvents.scsp) flagsNext.named.scsp = 1'b1;
		if (edgeEvents.sm) flagsNext.named.sm = 1'b1;
		if (edgeEvents.vdp1) flagsNext.named.vdp1 = 1'b1;
	end

	// Priority scan over the unmasked flags
	always_comb begin
		active.raw = flags.raw & ~ims;
		if (active.named.vbIn) scanLevel = 4'hF;
		else if (active.named.vbOut) scanLevel = 4'hE;
		else if (active.named.hbIn) scanLevel = 4'hD;
		else if (active.named.tm0) scanLevel = 4'hC;
		else if (active.named.tm1) scanLevel = 4'hB;
		else if (active.named.scsp) scanLevel = 4'h9;
		else if (active.named.sm) scanLevel = 4'h8;
		else if (active.named.vdp1) scanLevel = 4'h2;
		else scanLevel = 4'h0;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			flags <= '0;
			level <= '0;
		end else if (!resN) begin
			flags <= '0;
			level <= '0;
		end else begin
			flags <= flagsNext;
			// Level is held until acknowledged
			if (level == '0) level <= scanLevel;
			else if (vecFetch || istWrite) level <= '0;
		end
	end

	assign irqLevelN = ~level;

	always_comb begin
		case (cpuAddr)
			4'hF: vector = `VEC_VBIN;
			4'hE: vector = `VEC_VBOUT;
			4'hD: vector = `VEC_HBIN;
			4'hC: vector = `VEC_TM0;
			4'hB: vector = `VEC_TM1;
			4'h9: vector = `VEC_SCSP;
			4'h8: vector = `VEC_SM;
			4'h2: vector = `VEC_VDP1;
			default: vector = 8'h00;
		endcase
	end

endmodule

/* rtl/scuTimers.sv */
`timescale 1ns/1ps
`include "scu_defs.svh"

module scuTimers
	import scuRegPkg::*;
	import scuIntPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       resN,
	input  edgeEventsT edgeEvents,
	input  t0cT        t0c,
	input  t1sT        t1s,
	input  t1mdT       t1md,
	output logic       tm0Hit,
	output logic       tm1Hit
);
	t0cT               lineCnt;
	logic [`T1S_W+1:0] cycleCnt;
	logic              tm1Armed;
	logic              lineMatch;

	assign lineMatch = (lineCnt == t0c);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			lineCnt <= '0;
			cycleCnt <= '0;
			tm1Armed <= 1'b0;
			tm0Hit <= 1'b0;
			tm1Hit <= 1'b0;
		end else if (!resN) begin
			lineCnt <= '0;
			cycleCnt <= '0;
			tm1Armed <= 1'b0;
			tm0Hit <= 1'b0;
			tm1Hit <= 1'b0;
		end else begin
			tm0Hit <= 1'b0;
			tm1Hit <= 1'b0;
			if (t1md.enb) begin
				if (cycleCnt != '0) begin
					cycleCnt <= cycleCnt - 1'b1;
				end else if (tm1Armed) begin
					tm1Hit <= 1'b1;
					tm1Armed <= 1'b0;
				end
				// New line reloads timer 1 and steps timer 0
				if (edgeEvents.hbIn) begin
					lineCnt <= lineCnt + 1'b1;
					cycleCnt <= {t1s, 2'b11};
					tm1Armed <= !t1md.md || lineMatch;
					tm0Hit <= lineMatch;
				end
				if (edgeEvents.vbOut) lineCnt <= '0;
			end
		end
	end

endmodule

/* rtl/scuRegisters.sv */
`timescale 1ns/1ps
`include "scu_defs.svh"

module scuRegisters
	import scuRegPkg::*;
	import scuIntPkg::*;
(
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        resN,
	input  logic        regWrite,
	input  logic        regRead,
	input  regOfsT      regOfs,
	input  logic [3:0]  byteEnN,
	input  logic [31:0] cpuWriteData,
	input  intFlagsU    flags,
	output t0cT         t0c,
	output t1sT         t1s,
	output t1mdT        t1md,
	output imsT         ims,
	output logic [31:0] regReadWord
);
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			t0c <= '0;
			t1s <= '0;
			t1md <= '0;
			ims <= '0;
		end else if (!resN) begin
			t0c <= '0;
			t1s <= '0;
			t1md <= '0;
			ims <= '0;
		end else if (regWrite) begin
			// Only the lanes that hold field bits matter
			case ({regOfs, 2'b00})
				`OFS_T0C: begin
					if (!byteEnN[0]) t0c[7:0] <= cpuWriteData[7:0];
					if (!byteEnN[1]) t0c[`T0C_W-1:8] <= cpuWriteData[`T0C_W-1:8];
				end
				`OFS_T1S: begin
					if (!byteEnN[0]) t1s[7:0] <= cpuWriteData[7:0];
					if (!byteEnN[1]) t1s[`T1S_W-1:8] <= cpuWriteData[`T1S_W-1:8];
				end
				`OFS_T1MD: begin
					if (!byteEnN[0]) t1md.enb <= cpuWriteData[0];
					if (!byteEnN[1]) t1md.md <= cpuWriteData[8];
				end
				`OFS_IMS: begin
					if (!byteEnN[0]) ims[7:0] <= cpuWriteData[7:0];
					if (!byteEnN[1]) ims[15:8] <= cpuWriteData[15:8];
				end
				default: ;
			endcase
		end
	end

	// Timer and mask registers are write-only and read as zero
	always_comb begin
		regReadWord = '0;
		if (regRead && ({regOfs, 2'b00} == `OFS_IST)) begin
			regReadWord = {16'h0000, flags.raw};
		end
	end

endmodule

/* rtl/irqEdgeSync.sv */
`timescale 1ns/1ps

module irqEdgeSync
	import scuIntPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       resN,
	input  logic       vblankN,
	input  logic       hblankN,
	input  logic       soundIrqN,
	input  logic       spriteIrqN,
	input  logic       smpcIrqN,
	output edgeEventsT edgeEvents
);
	// Previous levels, in the order vblank, hblank, sound, sprite, smpc
	logic [4:0] levelOld;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			levelOld <= '1;
			edgeEvents <= '0;
		end else if (!resN) begin
			levelOld <= '1;
			edgeEvents <= '0;
		end else begin
			levelOld <= {vblankN, hblankN, soundIrqN, spriteIrqN, smpcIrqN};
			edgeEvents.vbIn <= levelOld[4] && !vblankN;
			// Blanking ends on the rising edge
			edgeEvents.vbOut <= !levelOld[4] && vblankN;
			edgeEvents.hbIn <= levelOld[3] && !hblankN;
			edgeEvents.scsp <= levelOld[2] && !soundIrqN;
			edgeEvents.vdp1 <= levelOld[1] && !spriteIrqN;
			edgeEvents.sm <= levelOld[0] && !smpcIrqN;
		end
	end

endmodule

/* rtl/hostBusPort.sv */
`timescale 1ns/1ps
`include "scu_defs.svh"

module hostBusPort
	import scuRegPkg::*;
	import scuIntPkg::*;
(
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        resN,
	input  logic [24:0] cpuAddr,
	input  logic [31:0] cpuWriteData,
	input  logic        regCsN,
	input  logic [3:0]  byteEnN,
	input  logic        readN,
	input  logic        vecFetchN,
	input  logic [31:0] regReadWord,
	input  vectorT      vector,
	output logic        regWrite,
	output logic        regRead,
	output logic        vecFetch,
	output regOfsT      regOfs,
	output logic [31:0] cpuReadData
);
	logic byteEnIdle;
	logic readNOld;
	logic regSel;
	logic writeEdge;
	logic readEdge;

	assign regSel = !regCsN && (cpuAddr >= `SCU_REG_BASE) && (cpuAddr <= `SCU_REG_LAST);
	// Lanes leave all-ones, or read strobe drops
	assign writeEdge = byteEnIdle && !(&byteEnN);
	assign readEdge = readNOld && !readN;
	assign regOfs = cpuAddr[7:2];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			byteEnIdle <= 1'b1;
			readNOld <= 1'b1;
			regWrite <= 1'b0;
			regRead <= 1'b0;
			vecFetch <= 1'b0;
		end else if (!resN) begin
			byteEnIdle <= 1'b1;
			readNOld <= 1'b1;
			regWrite <= 1'b0;
			regRead <= 1'b0;
			vecFetch <= 1'b0;
		end else begin
			byteEnIdle <= &byteEnN;
			readNOld <= readN;
			regWrite <= regSel && writeEdge;
			regRead <= regSel && readEdge;
			vecFetch <= !vecFetchN && readEdge;
		end
	end

	// Vector fetch wins over a register read
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cpuReadData <= '0;
		end else if (!resN) begin
			cpuReadData <= '0;
		end else if (vecFetch) begin
			cpuReadData <= {24'h000000, vector};
		end else if (regRead) begin
			cpuReadData <= regReadWord;
		end
	end

endmodule

/* rtl/scuIntPkg.sv */
package scuIntPkg;

	// IST bit layout, reserved bits stay zero
	typedef struct packed {
		logic [1:0] rsvHigh;
		logic       vdp1;
		logic [4:0] rsvMid;
		logic       sm;
		logic       scsp;
		logic       rsvLow;
		logic       tm1;
		logic       tm0;
		logic       hbIn;
		logic       vbOut;
		logic       vbIn;
	} intFlagsT;

	// Same 16 bits seen by name or as the IST word
	typedef union packed {
		intFlagsT    named;
		logic [15:0] raw;
	} intFlagsU;

	typedef logic [3:0] irqLevelT;
	typedef logic [7:0] vectorT;

	// One-cycle request pulses from the edge detector
	typedef struct packed {
		logic vbIn;
		logic vbOut;
		logic hbIn;
		logic scsp;
		logic vdp1;
		logic sm;
	} edgeEventsT;

endpackage

/* rtl/scuRegPkg.sv */
`include "scu_defs.svh"

package scuRegPkg;

	// Timer 0 compare value, in lines
	typedef logic [`T0C_W-1:0] t0cT;

	// Timer 1 reload, scaled by four plus three on load
	typedef logic [`T1S_W-1:0] t1sT;

	// Timer 1 mode, bit 8 and bit 0 of the written word
	typedef struct packed {
		logic md;
		logic enb;
	} t1mdT;

	// Interrupt mask, a set bit masks the source
	typedef logic [15:0] imsT;

	// Word offset inside the register window
	typedef logic [5:0] regOfsT;

endpackage

/* rtl/scu_defs.svh */
`ifndef SCU_DEFS_SVH
`define SCU_DEFS_SVH

// Register window on the CPU address, chip select 2
`define SCU_REG_BASE 25'h1FE0000
`define SCU_REG_LAST 25'h1FE00CF

// Byte offsets of the kept registers
`define OFS_T0C  8'h90
`define OFS_T1S  8'h94
`define OFS_T1MD 8'h98
`define OFS_IMS  8'hA0
`define OFS_IST  8'hA4

// Timer field widths
`define T0C_W 10
`define T1S_W 9

// Vector bytes returned on a vector fetch
`define VEC_VBIN  8'h40
`define VEC_VBOUT 8'h41
`define VEC_HBIN  8'h42
`define VEC_TM0   8'h43
`define VEC_TM1   8'h44
`define VEC_SCSP  8'h46
`define VEC_SM    8'h47
`define VEC_VDP1  8'h4D

`endif
